// File: logic/modexp_pkg.sv
// ==========================================================================
// Shared definitions for the modular exponentiation accelerator
//   - field element width and residue type
//   - requester ids used on the shared multiplier
//   - multiplier request and response words
// ==========================================================================

package modexp_pkg;

  // Width of one residue
  localparam int W = 16;

  typedef logic [W-1:0] elem_t;

  // Requester ids on the multiplier arbiter
  typedef logic [1:0] req_id_t;

  localparam req_id_t REQ_BASE  = 2'd0;
  localparam req_id_t REQ_ENG_A = 2'd1;
  localparam req_id_t REQ_ENG_B = 2'd2;

  // One multiply request, 34 bits
  typedef struct packed {
    elem_t   a;
    elem_t   b;
    req_id_t tag;
  } mult_req_t;

  // One multiply result, 18 bits
  typedef struct packed {
    elem_t   r;
    req_id_t tag;
  } mult_rsp_t;

endpackage

// File: logic/mod_mult.sv
// ==========================================================================
// Pipelined modular multiplier
//   Three stages: operand register, full product, reduction mod P_MOD.
//   Accepts one request per cycle, tag travels with the data.
// ==========================================================================
`timescale 1ns/1ps

module mod_mult #(
  parameter int P_MOD = 65521
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  modexp_pkg::mult_req_t i_req,
  input  logic                  i_req_val,
  output modexp_pkg::mult_rsp_t o_rsp,
  output logic                  o_rsp_val
);

  localparam int W = modexp_pkg::W;
  localparam logic [2*W-1:0] P_WIDE = (2*W)'(P_MOD);

  // Stage 1 operands
  modexp_pkg::elem_t   s1_a, s1_b;
  modexp_pkg::req_id_t s1_tag;
  logic                s1_val;

  // Stage 2 product
  logic [2*W-1:0]      s2_prod;
  modexp_pkg::req_id_t s2_tag;
  logic                s2_val;

  // Reduction of the full product
  logic [2*W-1:0]      s2_red;

  assign s2_red = s2_prod % P_WIDE;

  // Valid bits move down the pipe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val    <= 1'b0;
      s2_val    <= 1'b0;
      o_rsp_val <= 1'b0;
    end else begin
      s1_val    <= i_req_val;
      s2_val    <= s1_val;
      o_rsp_val <= s2_val;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_a      <= i_req.a;
    s1_b      <= i_req.b;
    s1_tag    <= i_req.tag;
    s2_prod   <= s1_a * s1_b;
    s2_tag    <= s1_tag;
    o_rsp.r   <= s2_red[W-1:0];
    o_rsp.tag <= s2_tag;
  end

endmodule

// File: logic/mult_arbiter.sv
// ==========================================================================
// Round-robin arbiter for the shared modular multiplier
//   Grants one of three requesters per cycle, stamps the winner's id
//   into the tag, and routes each response back by its tag.
// ==========================================================================
`timescale 1ns/1ps

module mult_arbiter (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  modexp_pkg::mult_req_t i_req [3],
  input  logic [2:0]            i_req_val,
  output logic [2:0]            o_gnt,
  output modexp_pkg::mult_req_t o_mreq,
  output logic                  o_mreq_val,
  input  modexp_pkg::mult_rsp_t i_mrsp,
  input  logic                  i_mrsp_val,
  output modexp_pkg::mult_rsp_t o_rsp,
  output logic [2:0]            o_rsp_val
);

  localparam int N = 3;

  // Index of the last requester granted
  logic [1:0] last;
  logic [1:0] win;
  logic       any;

  // Search starts just after the last winner
  always_comb begin
    win = last;
    any = 1'b0;
    for (int i = 1; i <= N; i++) begin
      int cand;
      cand = (int'(last) + i) % N;
      if (!any && i_req_val[cand]) begin
        any = 1'b1;
        win = cand[1:0];
      end
    end
  end

  always_comb begin
    o_gnt      = any ? (3'b001 << win) : 3'b000;
    o_mreq_val = any;
    o_mreq     = i_req[win];
    o_mreq.tag = win;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last <= 2'd2;
    end else if (any) begin
      last <= win;
    end
  end

  // Responses go only to the requester named in the tag
  assign o_rsp = i_mrsp;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_rsp_val[i] = i_mrsp_val && (i_mrsp.tag == 2'(i));
    end
  end

endmodule

// File: logic/base_power.sv
// ==========================================================================
// Decomposition stage
//   Squares the base H times through the shared multiplier to form
//   g2 = g^(2^H), then pulses o_done and holds the value.
// ==========================================================================
`timescale 1ns/1ps

module base_power #(
  parameter int H = 8
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_start,
  input  modexp_pkg::elem_t     i_base,
  output modexp_pkg::mult_req_t o_mreq,
  output logic                  o_mreq_val,
  input  logic                  i_mgnt,
  input  modexp_pkg::mult_rsp_t i_mrsp,
  input  logic                  i_mrsp_val,
  output logic                  o_done,
  output modexp_pkg::elem_t     o_g2
);

  localparam int CW = $clog2(H + 1);

  modexp_pkg::elem_t acc;
  logic [CW-1:0]     cnt;

  // Always a squaring, the arbiter fills in the tag
  always_comb begin
    o_mreq.a   = acc;
    o_mreq.b   = acc;
    o_mreq.tag = '0;
  end

  assign o_g2 = acc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt        <= '0;
      o_mreq_val <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_mgnt) o_mreq_val <= 1'b0;
      if (i_start) begin
        cnt        <= '0;
        o_mreq_val <= 1'b1;
      end else if (i_mrsp_val) begin
        if (cnt == CW'(H - 1)) begin
          o_done <= 1'b1;
        end else begin
          cnt        <= cnt + 1'b1;
          o_mreq_val <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) acc <= i_base;
    else if (i_mrsp_val) acc <= i_mrsp.r;
  end

endmodule

// File: logic/exp_engine.sv
// ==========================================================================
// Square-and-multiply engine for one half-exponent
//   Walks the exponent from the top bit down: square the accumulator,
//   then multiply by the base when the bit is set.
//   All products go through the shared multiplier.
// ==========================================================================
`timescale 1ns/1ps

module exp_engine #(
  parameter int H = 8
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_start,
  input  modexp_pkg::elem_t     i_base,
  input  logic [H-1:0]          i_exp,
  output modexp_pkg::mult_req_t o_mreq,
  output logic                  o_mreq_val,
  input  logic                  i_mgnt,
  input  modexp_pkg::mult_rsp_t i_mrsp,
  input  logic                  i_mrsp_val,
  output logic                  o_done,
  output modexp_pkg::elem_t     o_result
);

  localparam int IW = (H > 1) ? $clog2(H) : 1;

  modexp_pkg::elem_t acc;
  modexp_pkg::elem_t base_r;
  logic [H-1:0]      exp_r;
  logic [IW-1:0]     idx;
  // High while the pending product is the multiply by the base
  logic              mul_ph;

  always_comb begin
    o_mreq.a   = acc;
    o_mreq.b   = mul_ph ? base_r : acc;
    o_mreq.tag = '0;
  end

  assign o_result = acc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      idx        <= '0;
      mul_ph     <= 1'b0;
      o_mreq_val <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_mgnt) o_mreq_val <= 1'b0;
      if (i_start) begin
        idx    <= IW'(H - 1);
        mul_ph <= 1'b0;
        // Zero exponent needs no products at all
        if (i_exp == '0) begin
          o_done <= 1'b1;
        end else begin
          o_mreq_val <= 1'b1;
        end
      end else if (i_mrsp_val) begin
        if (!mul_ph && exp_r[idx]) begin
          mul_ph     <= 1'b1;
          o_mreq_val <= 1'b1;
        end else if (idx == '0) begin
          o_done <= 1'b1;
        end else begin
          // Next bit starts with a squaring
          idx        <= idx - 1'b1;
          mul_ph     <= 1'b0;
          o_mreq_val <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      acc    <= modexp_pkg::elem_t'(1);
      base_r <= i_base;
      exp_r  <= i_exp;
    end else if (i_mrsp_val) begin
      acc <= i_mrsp.r;
    end
  end

endmodule

// File: logic/split_exp_ctrl.sv
// ==========================================================================
// Split-exponent controller
//   Splits the exponent into halves, forms g2 = g^(2^H), runs two
//   engines in parallel, combines their results with one multiply,
//   and handles unreduced bases and output back-pressure.
// ==========================================================================
`timescale 1ns/1ps

module split_exp_ctrl #(
  parameter int P_MOD = 65521,
  parameter int K_W   = 16
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  modexp_pkg::elem_t     i_base,
  input  logic [K_W-1:0]        i_exp,
  input  logic                  i_val,
  output logic                  o_rdy,
  output modexp_pkg::elem_t     o_result,
  output logic                  o_err,
  output logic                  o_val,
  input  logic                  i_rdy,
  output modexp_pkg::mult_req_t o_mreq,
  output logic                  o_mreq_val,
  input  modexp_pkg::mult_rsp_t i_mrsp,
  input  logic                  i_mrsp_val
);

  localparam int H = K_W / 2;
  localparam modexp_pkg::elem_t P_ELEM = modexp_pkg::elem_t'(P_MOD);
  localparam modexp_pkg::req_id_t ID_B = modexp_pkg::REQ_BASE;
  localparam modexp_pkg::req_id_t ID_A = modexp_pkg::REQ_ENG_A;
  localparam modexp_pkg::req_id_t ID_E = modexp_pkg::REQ_ENG_B;

  typedef enum logic [2:0] {IDLE, DECOMPOSE, POWER, COMBINE, FINISHED} state_t;
  state_t state;

  modexp_pkg::mult_req_t req [3];
  modexp_pkg::mult_req_t bp_req, a_req, b_req, comb_req;
  modexp_pkg::mult_rsp_t rsp;
  logic [2:0]            req_val, gnt, rsp_val;
  logic                  bp_req_val, a_req_val, b_req_val, comb_val;
  logic                  start_bp, start_eng, bp_done, a_done, b_done;
  logic                  got_a, got_b, comb_sel;
  modexp_pkg::elem_t     base_r, g2, a_res, b_res, res_a, res_b;
  logic [K_W-1:0]        exp_r;

  // Engine A's arbiter slot carries the combine multiply once A is done
  assign comb_sel = (state == COMBINE);

  always_comb begin
    comb_req.a   = res_a;
    comb_req.b   = res_b;
    comb_req.tag = '0;
    req[ID_B]     = bp_req;
    req_val[ID_B] = bp_req_val;
    req[ID_A]     = comb_sel ? comb_req : a_req;
    req_val[ID_A] = comb_sel ? comb_val : a_req_val;
    req[ID_E]     = b_req;
    req_val[ID_E] = b_req_val;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
      o_rdy <= 1'b0;
      o_val <= 1'b0;
      o_err <= 1'b0;
      start_bp <= 1'b0;
      start_eng <= 1'b0;
      got_a <= 1'b0;
      got_b <= 1'b0;
      comb_val <= 1'b0;
    end else begin
      start_bp  <= 1'b0;
      start_eng <= 1'b0;
      if (gnt[ID_A] && comb_sel) comb_val <= 1'b0;
      case (state)
        IDLE: begin
          o_rdy <= 1'b1;
          if (o_rdy && i_val) begin
            o_rdy <= 1'b0;
            got_a <= 1'b0;
            got_b <= 1'b0;
            if (i_base >= P_ELEM) begin
              o_err <= 1'b1;
              o_val <= 1'b1;
              state <= FINISHED;
            end else begin
              o_err    <= 1'b0;
              start_bp <= 1'b1;
              state    <= DECOMPOSE;
            end
          end
        end
        DECOMPOSE: if (bp_done) begin
          start_eng <= 1'b1;
          state     <= POWER;
        end
        POWER: begin
          if (a_done) got_a <= 1'b1;
          if (b_done) got_b <= 1'b1;
          if ((got_a || a_done) && (got_b || b_done)) begin
            comb_val <= 1'b1;
            state    <= COMBINE;
          end
        end
        COMBINE: if (rsp_val[ID_A]) begin
          o_val <= 1'b1;
          state <= FINISHED;
        end
        FINISHED: if (i_rdy) begin
          o_val <= 1'b0;
          o_rdy <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Job operands and engine results
  always_ff @(posedge i_clk) begin
    if (state == IDLE && o_rdy && i_val) begin
      base_r <= i_base;
      exp_r  <= i_exp;
      if (i_base >= P_ELEM) o_result <= '0;
    end
    if (a_done) res_a <= a_res;
    if (b_done) res_b <= b_res;
    if (comb_sel && rsp_val[ID_A]) o_result <= rsp.r;
  end

  base_power #(.H(H)) u_base_power (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_bp), .i_base(base_r),
    .o_mreq(bp_req), .o_mreq_val(bp_req_val), .i_mgnt(gnt[ID_B]),
    .i_mrsp(rsp), .i_mrsp_val(rsp_val[ID_B]), .o_done(bp_done), .o_g2(g2)
  );

  exp_engine #(.H(H)) u_eng_a (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_eng), .i_base(base_r),
    .i_exp(exp_r[H-1:0]), .o_mreq(a_req), .o_mreq_val(a_req_val),
    .i_mgnt(gnt[ID_A] && !comb_sel), .i_mrsp(rsp),
    .i_mrsp_val(rsp_val[ID_A] && !comb_sel), .o_done(a_done), .o_result(a_res)
  );

  exp_engine #(.H(H)) u_eng_b (
    .i_clk(i_clk), .i_rst(i_rst), .i_start(start_eng), .i_base(g2),
    .i_exp(exp_r[K_W-1:H]), .o_mreq(b_req), .o_mreq_val(b_req_val),
    .i_mgnt(gnt[ID_E]), .i_mrsp(rsp), .i_mrsp_val(rsp_val[ID_E]),
    .o_done(b_done), .o_result(b_res)
  );

  mult_arbiter u_arb (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(req), .i_req_val(req_val), .o_gnt(gnt),
    .o_mreq(o_mreq), .o_mreq_val(o_mreq_val), .i_mrsp(i_mrsp),
    .i_mrsp_val(i_mrsp_val), .o_rsp(rsp), .o_rsp_val(rsp_val)
  );

endmodule

// File: logic/modexp_top.sv
// ==========================================================================
// Modular exponentiation accelerator top level
//   Split-exponent controller driving one shared modular multiplier
// ==========================================================================
`timescale 1ns/1ps

module modexp_top #(
  parameter int P_MOD = 65521,
  parameter int K_W   = 16
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  modexp_pkg::elem_t i_base,
  input  logic [K_W-1:0]    i_exp,
  input  logic              i_val,
  output logic              o_rdy,
  output modexp_pkg::elem_t o_result,
  output logic              o_err,
  output logic              o_val,
  input  logic              i_rdy
);

  modexp_pkg::mult_req_t mreq;
  modexp_pkg::mult_rsp_t mrsp;
  logic                  mreq_val, mrsp_val;

  split_exp_ctrl #(.P_MOD(P_MOD), .K_W(K_W)) u_ctrl (
    .i_clk(i_clk), .i_rst(i_rst), .i_base(i_base), .i_exp(i_exp), .i_val(i_val),
    .o_rdy(o_rdy), .o_result(o_result), .o_err(o_err), .o_val(o_val), .i_rdy(i_rdy),
    .o_mreq(mreq), .o_mreq_val(mreq_val), .i_mrsp(mrsp), .i_mrsp_val(mrsp_val)
  );

  mod_mult #(.P_MOD(P_MOD)) u_mult (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(mreq), .i_req_val(mreq_val),
    .o_rsp(mrsp), .o_rsp_val(mrsp_val)
  );

endmodule

// File: sim/modexp_sva.sv
// ==========================================================================
// Concurrent assertions for the accelerator top level
//   - result, error bit and o_val hold under back-pressure
//   - o_rdy and o_val are never high together
//   - output strobes stay low during reset
// ==========================================================================
`timescale 1ns/1ps

module modexp_sva (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_out_rdy,
  input logic              i_out_val,
  input logic              i_out_err,
  input modexp_pkg::elem_t i_out_result,
  input logic              i_sink_rdy
);

  // Output word is frozen until the sink takes it
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_out_val && !i_sink_rdy) |=>
      (i_out_val && $stable(i_out_result) && $stable(i_out_err)))
    else $error("Output changed or o_val dropped while i_rdy was low");

  a_excl: assert property (@(posedge i_clk) disable iff (i_rst) !(i_out_rdy && i_out_val))
    else $error("o_rdy and o_val were high in the same cycle");

  // Checked once reset has had an edge to act on
  a_reset: assert property (@(posedge i_clk)
    (i_rst && $past(i_rst)) |-> (!i_out_val && !i_out_rdy && !i_out_err))
    else $error("Output strobe high during reset");

endmodule

bind modexp_top modexp_sva u_sva (
  .i_clk(i_clk), .i_rst(i_rst), .i_out_rdy(o_rdy), .i_out_val(o_val),
  .i_out_err(o_err), .i_out_result(o_result), .i_sink_rdy(i_rdy)
);

// File: sim/tb_modexp.sv
// ==========================================================================
// Testbench for the modular exponentiation accelerator
//   - clock, reset and seeded random stimulus
//   - reference model by square-and-multiply modulo P_MOD
//   - typed compare tasks for the result and the error bit
//   - random, edge, back-pressure, error and back-to-back jobs
// ==========================================================================
`timescale 1ns/1ps

module tb_modexp;

  localparam int P_MOD    = 65521;
  localparam int K_W      = 16;
  localparam int H        = K_W / 2;
  localparam int MAX_WAIT = 2000;

  logic              i_clk;
  logic              i_rst;
  modexp_pkg::elem_t i_base;
  logic [K_W-1:0]    i_exp;
  logic              i_val;
  logic              o_rdy;
  modexp_pkg::elem_t o_result;
  logic              o_err;
  logic              o_val;
  logic              i_rdy;

  integer seed = 29;
  string  test_name;

  modexp_top #(.P_MOD(P_MOD), .K_W(K_W)) i_dut (
    .i_clk(i_clk), .i_rst(i_rst), .i_base(i_base), .i_exp(i_exp), .i_val(i_val),
    .o_rdy(o_rdy), .o_result(o_result), .o_err(o_err), .o_val(o_val), .i_rdy(i_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Left-to-right square-and-multiply over the whole exponent
  function automatic modexp_pkg::elem_t model_pow(input int unsigned base,
                                                  input logic [K_W-1:0] e);
    int unsigned acc;
    int          i;
    acc = 1;
    for (i = K_W - 1; i >= 0; i--) begin
      acc = (acc * acc) % P_MOD;
      if (e[i]) acc = (acc * base) % P_MOD;
    end
    return modexp_pkg::elem_t'(acc);
  endfunction

  function automatic modexp_pkg::elem_t pick_base();
    return modexp_pkg::elem_t'($unsigned($random(seed)) % P_MOD);
  endfunction

  function automatic logic [K_W-1:0] random_exponent();
    return K_W'($random(seed));
  endfunction

  task automatic check_result(input string name, input modexp_pkg::elem_t exp_v,
                              input modexp_pkg::elem_t act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: expected result %0d, actual %0d", name, exp_v, act_v);
      $display("Done: errors found");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_err(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("[ERROR] %s: expected o_err %0b, actual %0b", name, exp_v, act_v);
      $display("Done: errors found");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic stall_abort(input string what);
    $display("Test %s stalled: %s did not rise within %0d cycles", test_name, what, MAX_WAIT);
    $display("Done: errors found");
    $fatal(1, "DUT stalled");
  endtask

  // Waits for o_rdy, then presents the job for one accepting edge
  task automatic send_job(input modexp_pkg::elem_t base, input logic [K_W-1:0] e);
    int cycles;
    cycles = 0;
    while (!o_rdy) begin
      @(posedge i_clk);
      #1;
      cycles++;
      if (cycles > MAX_WAIT) stall_abort("o_rdy");
    end
    i_base = base;
    i_exp  = e;
    i_val  = 1'b1;
    @(posedge i_clk);
    #1;
    i_val = 1'b0;
  endtask

  // Waits for o_val, stalls the sink, then samples and consumes the result
  task automatic take_result(input int hold, output modexp_pkg::elem_t res, output logic err);
    int cycles;
    cycles = 0;
    while (!o_val) begin
      @(posedge i_clk);
      #1;
      cycles++;
      if (cycles > MAX_WAIT) stall_abort("o_val");
    end
    repeat (hold) begin
      @(posedge i_clk);
      #1;
    end
    res   = o_result;
    err   = o_err;
    i_rdy = 1'b1;
    @(posedge i_clk);
    #1;
    i_rdy = 1'b0;
  endtask

  task automatic run_job(input string name, input modexp_pkg::elem_t base,
                         input logic [K_W-1:0] e, input int hold);
    modexp_pkg::elem_t res;
    logic              err;
    test_name = name;
    send_job(base, e);
    take_result(hold, res, err);
    if (base >= P_MOD) begin
      check_err(name, 1'b1, err);
    end else begin
      check_err(name, 1'b0, err);
      check_result(name, model_pow(base, e), res);
    end
  endtask

  initial begin
    modexp_pkg::elem_t b;
    logic [K_W-1:0]    e;
    i_rst  = 1'b1;
    i_base = '0;
    i_exp  = '0;
    i_val  = 1'b0;
    i_rdy  = 1'b0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    for (int n = 0; n < 40; n++) run_job("random", pick_base(), random_exponent(), 0);

    // Edge exponents, each engine path alone
    b = pick_base();
    run_job("exp_zero", b, '0, 0);
    run_job("exp_one", b, K_W'(1), 0);
    run_job("base_zero", '0, random_exponent(), 0);
    run_job("max_operands", modexp_pkg::elem_t'(P_MOD - 1), '1, 0);
    for (int n = 0; n < 8; n++) begin
      e = random_exponent();
      e[H-1:0] = '0;
      run_job("exp_high_only", pick_base(), e, 0);
      e = random_exponent();
      e[K_W-1:H] = '0;
      run_job("exp_low_only", pick_base(), e, 0);
    end

    for (int n = 0; n < 30; n++) begin
      run_job("back_pressure", pick_base(), random_exponent(), $unsigned($random(seed)) % 6);
    end

    // Unreduced bases, each followed by a normal job
    run_job("base_is_modulus", modexp_pkg::elem_t'(P_MOD), random_exponent(), 0);
    run_job("after_error", pick_base(), random_exponent(), 0);
    run_job("base_all_ones", '1, random_exponent(), 2);
    run_job("after_error", pick_base(), random_exponent(), 0);
    for (int n = 0; n < 5; n++) begin
      b = modexp_pkg::elem_t'(P_MOD + $unsigned($random(seed)) % (2**modexp_pkg::W - P_MOD));
      run_job("base_unreduced", b, random_exponent(), 0);
      run_job("after_error", pick_base(), random_exponent(), 0);
    end

    for (int n = 0; n < 250; n++) run_job("back_to_back", pick_base(), random_exponent(), 0);

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: build.f
logic/modexp_pkg.sv
logic/mod_mult.sv
logic/mult_arbiter.sv
logic/base_power.sv
logic/exp_engine.sv
logic/split_exp_ctrl.sv
logic/modexp_top.sv
sim/modexp_sva.sv
sim/tb_modexp.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_modexp -Mdir obj_dir -f build.f \
  && ./obj_dir/Vtb_modexp \
  || { echo "simulation failed"; exit 1; }
